/* hdl/video_params.svh */
`ifndef VIDEO_PARAMS_SVH
`define VIDEO_PARAMS_SVH

`define COORD_W          11              // Horizontal and vertical count width

// Mode switch codes
`define SW_VGA           4'b0000
`define SW_SVGA          4'b0001
`define SW_XGA           4'b0011
`define SW_HDTV720P      4'b0010
`define SW_SXGA          4'b1000
`define SW_CAMERA        4'b1001

//////////////////////////////////////////////////////////////////////
// Per-mode timing, pixels or lines per field
//////////////////////////////////////////////////////////////////////
`define HPIXELS_VGA      11'd640         // 640x480@60
`define VLINES_VGA       11'd480
`define HSYNCPW_VGA      11'd96
`define VSYNCPW_VGA      11'd2
`define HFNPRCH_VGA      11'd16
`define VFNPRCH_VGA      11'd11
`define HBKPRCH_VGA      11'd48
`define VBKPRCH_VGA      11'd31

`define HPIXELS_SVGA     11'd800         // 800x600@60
`define VLINES_SVGA      11'd600
`define HSYNCPW_SVGA     11'd128
`define VSYNCPW_SVGA     11'd4
`define HFNPRCH_SVGA     11'd40
`define VFNPRCH_SVGA     11'd1
`define HBKPRCH_SVGA     11'd88
`define VBKPRCH_SVGA     11'd23

`define HPIXELS_XGA      11'd1024        // 1024x768@60
`define VLINES_XGA       11'd768
`define HSYNCPW_XGA      11'd136
`define VSYNCPW_XGA      11'd6
`define HFNPRCH_XGA      11'd24
`define VFNPRCH_XGA      11'd3
`define HBKPRCH_XGA      11'd160
`define VBKPRCH_XGA      11'd29

`define HPIXELS_HDTV720P 11'd1280        // 1280x720@60
`define VLINES_HDTV720P  11'd720
`define HSYNCPW_HDTV720P 11'd40
`define VSYNCPW_HDTV720P 11'd5
`define HFNPRCH_HDTV720P 11'd110
`define VFNPRCH_HDTV720P 11'd5
`define HBKPRCH_HDTV720P 11'd220
`define VBKPRCH_HDTV720P 11'd20

`define HPIXELS_SXGA     11'd1280        // 1280x1024@60
`define VLINES_SXGA      11'd1024
`define HSYNCPW_SXGA     11'd112
`define VSYNCPW_SXGA     11'd3
`define HFNPRCH_SXGA     11'd48
`define VFNPRCH_SXGA     11'd1
`define HBKPRCH_SXGA     11'd248
`define VBKPRCH_SXGA     11'd38

`define HPIXELS_CAMERA   11'd1280        // Camera variant of 720p
`define VLINES_CAMERA    11'd720
`define HSYNCPW_CAMERA   11'd39
`define VSYNCPW_CAMERA   11'd4
`define HFNPRCH_CAMERA   11'd110
`define VFNPRCH_CAMERA   11'd4
`define HBKPRCH_CAMERA   11'd220
`define VBKPRCH_CAMERA   11'd22

// Aux data island
`define AUX_BURST_LEN    31              // Cycles of ade per burst
`define AUX_W            24
`define AUX_START_LSB    13              // Start field is 11 bits from here

`define UART_DIV_DEFAULT 16              // pclk cycles per UART bit

`endif

/* hdl/video_pkg.sv */
`include "video_params.svh"

package video_pkg;

	typedef logic [`COORD_W-1:0] coord_t;    // Pixel or line count
	typedef logic [3:0]          mode_sw_t;  // Raw mode switch code

	// Last pixel or line of each timing region
	typedef struct packed {
		coord_t hsblnk;     // Last active pixel
		coord_t hssync;     // Last pixel before hsync
		coord_t hesync;     // Last hsync pixel
		coord_t heblnk;     // Last pixel of the line
		coord_t vsblnk;
		coord_t vssync;
		coord_t vesync;
		coord_t veblnk;
	} timing_t;

	typedef struct packed {
		logic hsync;
		logic vsync;
		logic vde;
		logic hblank_start; // One pulse at first blank pixel
	} sync_t;

endpackage

/* hdl/aux_pkg.sv */
`include "video_params.svh"

package aux_pkg;

	typedef logic [`AUX_W-1:0] aux_word_t;  // Aux FIFO word

	// Data-island scheduler
	typedef enum logic [2:0] {
		FIRST,          // Wait for the first aux write
		READY,          // Wait for active video
		IDLE,           // Wait for the target position
		ADE,            // Burst running
		ADE_L           // Last burst cycle, chain or rearm
	} aux_state_t;

	typedef struct packed {
		logic [3:0] aux0;
		logic [3:0] aux1;
		logic [3:0] aux2;
	} aux_nib_t;

	typedef logic [7:0] dump_byte_t;

endpackage

/* hdl/mode_table.sv */
`timescale 1ns/1ps
`include "video_params.svh"

module mode_table (
	input  logic                pclk,
	input  logic                RSTBTN,
	input  video_pkg::mode_sw_t sw,
	output video_pkg::timing_t  limits,
	output logic                polarity    // 1 means negative sync
);
	import video_pkg::*;

	mode_sw_t sw_meta;
	mode_sw_t sw_sync;
	mode_sw_t sw_q;

	// Region ends from the visible size, porches and sync width
	function automatic timing_t mode_limits(
		input coord_t hpix,
		input coord_t hfp,
		input coord_t hsw,
		input coord_t hbp,
		input coord_t vlin,
		input coord_t vfp,
		input coord_t vsw,
		input coord_t vbp
	);
		timing_t t;
		t.hsblnk = hpix - 1'b1;
		t.hssync = t.hsblnk + hfp;
		t.hesync = t.hssync + hsw;
		t.heblnk = t.hesync + hbp;
		t.vsblnk = vlin - 1'b1;
		t.vssync = t.vsblnk + vfp;
		t.vesync = t.vssync + vsw;
		t.veblnk = t.vesync + vbp;
		return t;
	endfunction

	//////////////////////////////////////////////////////////////////////
	// Switch synchronizer and hold register
	//////////////////////////////////////////////////////////////////////
	always_ff @(posedge pclk) begin
		if (RSTBTN) begin
			sw_meta <= `SW_HDTV720P;
			sw_sync <= `SW_HDTV720P;
			sw_q    <= `SW_HDTV720P;
		end else begin
			sw_meta <= sw;
			sw_sync <= sw_meta;
			sw_q    <= sw_sync;          // Third stage feeds the decode
		end
	end

	always_comb begin
		polarity = 1'b0;
		case (sw_q)
			`SW_VGA: begin
				polarity = 1'b1;
				limits = mode_limits(`HPIXELS_VGA, `HFNPRCH_VGA, `HSYNCPW_VGA, `HBKPRCH_VGA,
					`VLINES_VGA, `VFNPRCH_VGA, `VSYNCPW_VGA, `VBKPRCH_VGA);
			end
			`SW_SVGA: limits = mode_limits(`HPIXELS_SVGA, `HFNPRCH_SVGA, `HSYNCPW_SVGA,
				`HBKPRCH_SVGA, `VLINES_SVGA, `VFNPRCH_SVGA, `VSYNCPW_SVGA, `VBKPRCH_SVGA);
			`SW_XGA: begin
				polarity = 1'b1;
				limits = mode_limits(`HPIXELS_XGA, `HFNPRCH_XGA, `HSYNCPW_XGA, `HBKPRCH_XGA,
					`VLINES_XGA, `VFNPRCH_XGA, `VSYNCPW_XGA, `VBKPRCH_XGA);
			end
			`SW_SXGA: limits = mode_limits(`HPIXELS_SXGA, `HFNPRCH_SXGA, `HSYNCPW_SXGA,
				`HBKPRCH_SXGA, `VLINES_SXGA, `VFNPRCH_SXGA, `VSYNCPW_SXGA, `VBKPRCH_SXGA);
			`SW_CAMERA: limits = mode_limits(`HPIXELS_CAMERA, `HFNPRCH_CAMERA,
				`HSYNCPW_CAMERA, `HBKPRCH_CAMERA, `VLINES_CAMERA, `VFNPRCH_CAMERA,
				`VSYNCPW_CAMERA, `VBKPRCH_CAMERA);
			default: limits = mode_limits(`HPIXELS_HDTV720P, `HFNPRCH_HDTV720P,
				`HSYNCPW_HDTV720P, `HBKPRCH_HDTV720P, `VLINES_HDTV720P, `VFNPRCH_HDTV720P,
				`VSYNCPW_HDTV720P, `VBKPRCH_HDTV720P);   // 720p and unknown codes
		endcase
	end

	// Back porch must leave room after hsync for the line to close
	a_heblnk_after_sync: assert property (@(posedge pclk) disable iff (RSTBTN)
		limits.heblnk > limits.hesync);

endmodule

/* hdl/video_timing.sv */
`timescale 1ns/1ps

module video_timing (
	input  logic               pclk,
	input  logic               RSTBTN,
	input  video_pkg::timing_t limits,
	input  logic               polarity,
	output video_pkg::coord_t  hcount,
	output video_pkg::coord_t  vcount,
	output video_pkg::sync_t   sync
);
	import video_pkg::*;

	logic  h_wrap;
	logic  v_wrap;
	logic  hblnk;
	logic  vblnk;
	logic  hsync_int;
	logic  vsync_int;
	logic  hbl_start;
	sync_t sync_d1;

	// Compare with >= so a shorter mode wraps at once
	assign h_wrap = hcount >= limits.heblnk;
	assign v_wrap = vcount >= limits.veblnk;

	//////////////////////////////////////////////////////////////////////
	// Pixel and line counters
	//////////////////////////////////////////////////////////////////////
	always_ff @(posedge pclk) begin
		if (RSTBTN) begin
			hcount <= '0;
			vcount <= '0;
		end else if (h_wrap) begin
			hcount <= '0;
			vcount <= v_wrap ? '0 : vcount + 1'b1;
		end else begin
			hcount <= hcount + 1'b1;
		end
	end

	assign hblnk     = hcount > limits.hsblnk;
	assign vblnk     = vcount > limits.vsblnk;
	assign hsync_int = (hcount > limits.hssync) && (hcount <= limits.hesync);
	assign vsync_int = (vcount > limits.vssync) && (vcount <= limits.vesync);
	assign hbl_start = hcount == limits.hsblnk + 1'b1;    // First blank pixel

	// Two-stage output alignment, polarity in the first stage
	always_ff @(posedge pclk) begin
		if (RSTBTN) begin
			sync_d1 <= '{hsync: polarity, vsync: polarity, vde: 1'b0, hblank_start: 1'b0};
			sync    <= '{hsync: polarity, vsync: polarity, vde: 1'b0, hblank_start: 1'b0};
		end else begin
			sync_d1.hsync        <= hsync_int ^ polarity;
			sync_d1.vsync        <= vsync_int ^ polarity;
			sync_d1.vde          <= !hblnk && !vblnk;
			sync_d1.hblank_start <= hbl_start;
			sync                 <= sync_d1;
		end
	end

	// Only a mode change can leave hcount past the new line end
	a_hcount_in_line: assert property (@(posedge pclk) disable iff (RSTBTN)
		$stable(limits) |-> hcount <= limits.heblnk);

endmodule

/* hdl/aux_scheduler.sv */
`timescale 1ns/1ps
`include "video_params.svh"

module aux_scheduler (
	input  logic               pclk,
	input  logic               RSTBTN,
	input  video_pkg::coord_t  hcount,
	input  video_pkg::coord_t  vcount,
	input  logic               vde,
	input  logic               hsync,
	input  logic               vsync,
	input  logic               aux_wr,
	input  aux_pkg::aux_word_t aux_in,
	input  aux_pkg::aux_word_t aux_head,
	output logic               ade,         // Also the aux FIFO read enable
	output logic               burst_end,
	output aux_pkg::aux_nib_t  aux
);
	import video_pkg::*;
	import aux_pkg::*;

	localparam int CNT_W = $clog2(`AUX_BURST_LEN);

	aux_state_t       state;
	logic [CNT_W-1:0] acnt;
	coord_t           target;                // Next burst start position
	coord_t           head_start;
	coord_t           in_start;

	assign head_start = aux_head[`AUX_START_LSB +: `COORD_W];
	assign in_start   = aux_in[`AUX_START_LSB +: `COORD_W];
	assign burst_end  = state == ADE_L;

	assign aux.aux0 = {1'b1, aux_head[0], vsync, hsync};
	assign aux.aux1 = aux_head[4:1];
	assign aux.aux2 = aux_head[8:5];

	//////////////////////////////////////////////////////////////////////
	// Data-island FSM
	//////////////////////////////////////////////////////////////////////
	always_ff @(posedge pclk) begin
		if (RSTBTN) begin
			state  <= FIRST;
			acnt   <= '0;
			target <= '0;
			ade    <= 1'b0;
		end else begin
			case (state)
				FIRST: begin
					ade <= 1'b0;
					if (aux_wr) begin
						target <= in_start;     // First word sets the position
						state  <= READY;
					end
				end
				READY: if (vde) state <= IDLE;
				IDLE: begin
					ade <= 1'b0;
					if (hcount == target) begin
						acnt  <= '0;
						state <= ADE;
					end
				end
				ADE: begin
					acnt <= acnt + 1'b1;
					ade  <= 1'b1;
					if (acnt == CNT_W'(`AUX_BURST_LEN - 1))
						state <= ADE_L;
				end
				ADE_L: begin
					if (hcount == head_start) begin
						acnt  <= '0;            // Chain, ade stays high
						state <= ADE;
					end else begin
						ade    <= 1'b0;
						target <= head_start;
						state  <= IDLE;
					end
				end
				default: state <= FIRST;
			endcase
		end
	end

	a_burst_len: assert property (@(posedge pclk) disable iff (RSTBTN)
		$rose(ade) |-> ##(`AUX_BURST_LEN + 1) (!ade || state == ADE));

endmodule

/* hdl/aux_dump.sv */
`timescale 1ns/1ps

module aux_dump (
	input  logic                pclk,
	input  logic                RSTBTN,
	input  logic                burst_end,
	input  video_pkg::coord_t   hcount,
	input  video_pkg::coord_t   vcount,
	input  video_pkg::coord_t   start,
	input  logic                busy,
	output aux_pkg::dump_byte_t tx_byte,
	output logic                send
);
	import aux_pkg::*;

	logic [39:0] mem;          // vcount, hcount, 7 zeros, start
	logic [3:0]  cnt;          // Character index 0..11
	logic        sending;
	logic        capture;
	logic        issue;

	function automatic dump_byte_t hex_char(input logic [3:0] nib);
		if (nib < 4'd10)
			hex_char = 8'h30 + 8'(nib);
		else
			hex_char = 8'h37 + 8'(nib);    // Upper-case A..F
	endfunction

	assign capture = burst_end && !sending;        // Dropped while a line is out
	assign issue   = sending && !busy && !send;    // busy lags send by one cycle

	always_ff @(posedge pclk) begin
		if (RSTBTN) begin
			sending <= 1'b0;
			cnt     <= '0;
			send    <= 1'b0;
		end else begin
			send <= issue;
			if (capture) begin
				sending <= 1'b1;
				cnt     <= '0;
			end else if (issue) begin
				if (cnt == 4'd11) begin
					sending <= 1'b0;
					cnt     <= '0;
				end else begin
					cnt <= cnt + 1'b1;
				end
			end
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Text payload
	//////////////////////////////////////////////////////////////////////
	always_ff @(posedge pclk) begin
		if (capture) begin
			mem <= {vcount, hcount, 7'd0, start};
		end else if (issue) begin
			case (cnt)
				4'd10: tx_byte <= 8'h0d;   // CR
				4'd11: tx_byte <= 8'h0a;   // LF
				default: begin
					tx_byte <= hex_char(mem[39:36]);
					mem     <= {mem[35:0], 4'd0};
				end
			endcase
		end
	end

endmodule

/* hdl/uart_tx.sv */
`timescale 1ns/1ps
`include "video_params.svh"

module uart_tx #(
	parameter int DIV = `UART_DIV_DEFAULT
) (
	input  logic                pclk,
	input  logic                RSTBTN,
	input  aux_pkg::dump_byte_t tx_byte,
	input  logic                send,
	output logic                busy,
	output logic                uart_tx
);
	localparam int DIV_W = $clog2(DIV + 1);

	logic [DIV_W-1:0] div_cnt;
	logic [3:0]       bit_cnt;
	logic [9:0]       shreg;        // Stop, data, start

	assign uart_tx = shreg[0];

	always_ff @(posedge pclk) begin
		if (RSTBTN) begin
			busy    <= 1'b0;
			div_cnt <= '0;
			bit_cnt <= '0;
			shreg   <= '1;           // Line idles high
		end else if (!busy) begin
			if (send) begin
				shreg   <= {1'b1, tx_byte, 1'b0};
				busy    <= 1'b1;
				div_cnt <= '0;
				bit_cnt <= '0;
			end
		end else if (div_cnt == DIV_W'(DIV - 1)) begin
			div_cnt <= '0;
			shreg   <= {1'b1, shreg[9:1]};   // LSB first
			if (bit_cnt == 4'd9)
				busy <= 1'b0;                // End of stop bit
			else
				bit_cnt <= bit_cnt + 1'b1;
		end else begin
			div_cnt <= div_cnt + 1'b1;
		end
	end

endmodule

/* hdl/video_aux_top.sv */
`timescale 1ns/1ps
`include "video_params.svh"

module video_aux_top #(
	parameter int UART_DIV = `UART_DIV_DEFAULT
) (
	input  logic               pclk,
	input  logic               RSTBTN,
	input  video_pkg::mode_sw_t sw,
	input  logic               aux_wr,
	input  aux_pkg::aux_word_t aux_in,
	input  aux_pkg::aux_word_t aux_head,     // Head of the aux FIFO
	output video_pkg::sync_t   sync_out,
	output logic               ade,
	output aux_pkg::aux_nib_t  aux,
	output logic               uart_tx
);
	import video_pkg::*;
	import aux_pkg::*;

	timing_t    limits;
	logic       polarity;
	coord_t     hcount;
	coord_t     vcount;
	sync_t      sync;
	logic       burst_end;
	dump_byte_t tx_byte;
	logic       send;
	logic       busy;

	//////////////////////////////////////////////////////////////////////
	// Display timing
	//////////////////////////////////////////////////////////////////////
	mode_table i_mode_table (.pclk(pclk), .RSTBTN(RSTBTN), .sw(sw), .limits(limits),
		.polarity(polarity));

	video_timing i_video_timing (.pclk(pclk), .RSTBTN(RSTBTN), .limits(limits),
		.polarity(polarity), .hcount(hcount), .vcount(vcount), .sync(sync));

	assign sync_out = '{hsync: sync.hsync, vsync: sync.vsync, vde: sync.vde,
		hblank_start: 1'b0};

	//////////////////////////////////////////////////////////////////////
	// Data islands and debug dump
	//////////////////////////////////////////////////////////////////////
	aux_scheduler i_aux_scheduler (.pclk(pclk), .RSTBTN(RSTBTN), .hcount(hcount),
		.vcount(vcount), .vde(sync.vde), .hsync(sync.hsync), .vsync(sync.vsync),
		.aux_wr(aux_wr), .aux_in(aux_in), .aux_head(aux_head), .ade(ade),
		.burst_end(burst_end), .aux(aux));

	aux_dump i_aux_dump (.pclk(pclk), .RSTBTN(RSTBTN), .burst_end(burst_end),
		.hcount(hcount), .vcount(vcount), .start(aux_head[`AUX_START_LSB +: `COORD_W]),
		.busy(busy), .tx_byte(tx_byte), .send(send));

	uart_tx #(.DIV(UART_DIV)) i_uart_tx (.pclk(pclk), .RSTBTN(RSTBTN), .tx_byte(tx_byte),
		.send(send), .busy(busy), .uart_tx(uart_tx));

endmodule

/* sim/tb_clk.sv */
`timescale 1ns/1ps

module tb_clk #(
	parameter int HALF_NS = 50       // 100 ns period
) (
	output logic pclk
);

	initial pclk = 1'b0;

	always #(HALF_NS) pclk = ~pclk;

endmodule

/* sim/tb_video_aux.sv */
`timescale 1ns/1ps
`include "video_params.svh"

module tb_video_aux;
	import video_pkg::*;
	import aux_pkg::*;

	localparam int UDIV   = 8;          // pclk cycles per UART bit
	localparam int MARGIN = 20000;      // Cycles on top of the frame budget

	logic pclk, RSTBTN, aux_wr, ade, uart_tx;
	mode_sw_t sw;
	aux_word_t aux_in, aux_head;
	sync_t sync_out;
	aux_nib_t aux;

	integer seed = 32'h546e;
	int errors = 0, hs_checks = 0, vde_checks = 0, vs_checks = 0;
	int burst_checks = 0, dump_checks = 0;
	int cyc, hs_rise, vs_rise, vde_rise, ade_rise, cur_target, last_head_start;
	logic hs_prev, vs_prev, vde_prev, ade_prev, check_en, exp_pol;
	timing_t exp_t;
	aux_word_t fifo[$];                 // Aux FIFO model, head at index 0
	logic [21:0] bursts[$];             // Expected dump hcount and start per burst
	dump_byte_t rx_line[$];

	tb_clk i_tb_clk (.pclk(pclk));

	video_aux_top #(.UART_DIV(UDIV)) i_video_aux_top (.pclk(pclk), .RSTBTN(RSTBTN), .sw(sw),
		.aux_wr(aux_wr), .aux_in(aux_in), .aux_head(aux_head), .sync_out(sync_out), .ade(ade),
		.aux(aux), .uart_tx(uart_tx));

	//////////////////////////////////////////////////////////////////////
	// Reference model
	//////////////////////////////////////////////////////////////////////
	function automatic timing_t ref_limits(input mode_sw_t m);
		coord_t hp, hf, hs, hb, vl, vf, vs, vb;
		timing_t t;
		case (m)
			`SW_VGA: {hp, hf, hs, hb, vl, vf, vs, vb} = {`HPIXELS_VGA, `HFNPRCH_VGA,
				`HSYNCPW_VGA, `HBKPRCH_VGA, `VLINES_VGA, `VFNPRCH_VGA, `VSYNCPW_VGA, `VBKPRCH_VGA};
			`SW_SVGA: {hp, hf, hs, hb, vl, vf, vs, vb} = {`HPIXELS_SVGA, `HFNPRCH_SVGA,
				`HSYNCPW_SVGA, `HBKPRCH_SVGA, `VLINES_SVGA, `VFNPRCH_SVGA, `VSYNCPW_SVGA,
				`VBKPRCH_SVGA};
			`SW_XGA: {hp, hf, hs, hb, vl, vf, vs, vb} = {`HPIXELS_XGA, `HFNPRCH_XGA,
				`HSYNCPW_XGA, `HBKPRCH_XGA, `VLINES_XGA, `VFNPRCH_XGA, `VSYNCPW_XGA, `VBKPRCH_XGA};
			`SW_SXGA: {hp, hf, hs, hb, vl, vf, vs, vb} = {`HPIXELS_SXGA, `HFNPRCH_SXGA,
				`HSYNCPW_SXGA, `HBKPRCH_SXGA, `VLINES_SXGA, `VFNPRCH_SXGA, `VSYNCPW_SXGA,
				`VBKPRCH_SXGA};
			`SW_CAMERA: {hp, hf, hs, hb, vl, vf, vs, vb} = {`HPIXELS_CAMERA, `HFNPRCH_CAMERA,
				`HSYNCPW_CAMERA, `HBKPRCH_CAMERA, `VLINES_CAMERA, `VFNPRCH_CAMERA,
				`VSYNCPW_CAMERA, `VBKPRCH_CAMERA};
			default: {hp, hf, hs, hb, vl, vf, vs, vb} = {`HPIXELS_HDTV720P, `HFNPRCH_HDTV720P,
				`HSYNCPW_HDTV720P, `HBKPRCH_HDTV720P, `VLINES_HDTV720P, `VFNPRCH_HDTV720P,
				`VSYNCPW_HDTV720P, `VBKPRCH_HDTV720P};
		endcase
		t.hsblnk = hp - 11'd1;          // Last visible pixel
		t.hssync = t.hsblnk + hf;
		t.hesync = t.hssync + hs;
		t.heblnk = t.hesync + hb;
		t.vsblnk = vl - 11'd1;
		t.vssync = t.vsblnk + vf;
		t.vesync = t.vssync + vs;
		t.veblnk = t.vesync + vb;
		return t;
	endfunction

	function automatic logic ref_polarity(input mode_sw_t m);
		return (m == `SW_VGA) || (m == `SW_XGA);     // Negative sync modes
	endfunction

	function automatic int line_len(input timing_t t);
		return int'(t.heblnk) + 1;
	endfunction

	function automatic int frame_len(input timing_t t);
		return line_len(t) * (int'(t.veblnk) + 1);
	endfunction

	function automatic int wrap_mod(input int a, input int m);
		return ((a % m) + m) % m;
	endfunction

	// Start below 600 with bit 5 clear, so target+32 never equals a start
	function automatic aux_word_t new_word();
		logic [31:0] r;
		coord_t start;
		r = $random(seed);
		start = 11'(r[11:8] % 4'd9) * 11'd64 + 11'(r[4:0]);
		return {start, r[27:15]};
	endfunction

	function automatic logic [79:0] hex_text(input logic [39:0] v);
		logic [79:0] t;
		logic [3:0] nib;
		t = '0;
		for (int i = 0; i < 10; i++) begin
			nib = v[39 - 4*i -: 4];
			t = {t[71:0], (nib < 4'd10) ? 8'h30 + 8'(nib) : 8'h41 + 8'(nib) - 8'd10};
		end
		return t;
	endfunction

	function automatic logic [3:0] hex_digit(input dump_byte_t c);
		if (c >= 8'h30 && c <= 8'h39)
			return 4'(c - 8'h30);
		else if (c >= 8'h41 && c <= 8'h46)
			return 4'(c - 8'h37);
		return 4'd0;                    // Bad characters fail the text compare
	endfunction

	task automatic report_mismatch(input string msg);
		$display("[FAIL] %0t ns: %s", $time, msg);
		errors++;
	endtask

	task automatic report_problem(input string msg);
		$display("ERROR: %s", msg);
		errors++;
	endtask

	task automatic clear_trackers();
		hs_rise  = -1;
		vs_rise  = -1;
		vde_rise = -1;
	endtask

	//////////////////////////////////////////////////////////////////////
	// FIFO model and checker, all on the falling edge
	//////////////////////////////////////////////////////////////////////
	always @(negedge pclk) begin : monitor
		logic hs_act, vs_act;
		int want;
		cyc++;
		if (!RSTBTN) begin
			if (ade) begin                      // Head word of the cycle just ended
				assert (aux.aux1 == aux_head[4:1] && aux.aux2 == aux_head[8:5] && aux.aux0 ==
					{1'b1, aux_head[0], sync_out.vsync, sync_out.hsync}) else report_mismatch(
					$sformatf("aux nibbles %h for head %h", aux, aux_head));
			end
			assert (!sync_out.hblank_start) else report_mismatch(
				"hblank_start is not tied off at the top level");
			if (ade_prev) begin                 // Pop after each ade cycle
				void'(fifo.pop_front());
				fifo.push_back(new_word());
				aux_head = fifo[0];
			end
			hs_act = sync_out.hsync ^ exp_pol;
			vs_act = sync_out.vsync ^ exp_pol;
			if (hs_act && !hs_prev) begin
				if (check_en && hs_rise >= 0) begin
					assert (cyc - hs_rise == line_len(exp_t)) else report_mismatch($sformatf(
						"hsync period %0d, expected %0d", cyc - hs_rise, line_len(exp_t)));
					hs_checks++;
				end
				hs_rise = cyc;
			end
			if (!hs_act && hs_prev && check_en && hs_rise >= 0) begin
				want = int'(exp_t.hesync - exp_t.hssync);
				assert (cyc - hs_rise == want) else report_mismatch($sformatf(
					"hsync width %0d, expected %0d", cyc - hs_rise, want));
			end
			if (vs_act && !vs_prev) begin
				if (check_en && vs_rise >= 0) begin
					assert (cyc - vs_rise == frame_len(exp_t)) else report_mismatch($sformatf(
						"vsync period %0d, expected %0d", cyc - vs_rise, frame_len(exp_t)));
					vs_checks++;
				end
				vs_rise = cyc;
			end
			if (sync_out.vde && !vde_prev)
				vde_rise = cyc;
			if (!sync_out.vde && vde_prev && check_en && vde_rise >= 0) begin
				assert (cyc - vde_rise == int'(exp_t.hsblnk) + 1) else report_mismatch(
					$sformatf("vde run of %0d pixels", cyc - vde_rise));
				vde_checks++;
			end
			if (ade && !ade_prev) begin
				ade_rise = cyc;
				if (check_en && hs_rise >= 0 && cur_target >= 0) begin
					want = wrap_mod(cur_target - int'(exp_t.hssync) - 1, line_len(exp_t));
					assert (cyc - hs_rise == want) else report_mismatch($sformatf(
						"ade rose %0d after hsync, expected %0d", cyc - hs_rise, want));
				end
			end
			if (!ade && ade_prev && ade_rise >= 0) begin
				assert (cyc - ade_rise == `AUX_BURST_LEN) else report_mismatch($sformatf(
					"ade burst of %0d cycles", cyc - ade_rise));
				burst_checks++;
				bursts.push_back({11'(cur_target + 32), 11'(last_head_start)});
				if (bursts.size() > 64)
					void'(bursts.pop_front());
				cur_target = last_head_start;   // Head at burst end sets the next one
			end
			if (ade)
				last_head_start = int'(aux_head[`AUX_START_LSB +: `COORD_W]);
			hs_prev  = hs_act;
			vs_prev  = vs_act;
			vde_prev = sync_out.vde;
			ade_prev = ade;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// UART decoder
	//////////////////////////////////////////////////////////////////////
	task automatic take_byte(input dump_byte_t b);
		logic [79:0] text;
		logic [39:0] val;
		int hit;
		rx_line.push_back(b);
		if (b == 8'h0a) begin
			assert (rx_line.size() == 12 && rx_line[10] == 8'h0d) else report_mismatch(
				$sformatf("dump line of %0d bytes without CR LF ending", rx_line.size()));
			if (rx_line.size() == 12) begin
				text = '0;
				val  = '0;
				hit  = -1;
				for (int i = 0; i < 10; i++) begin
					text = {text[71:0], rx_line[i]};
					val  = {val[35:0], hex_digit(rx_line[i])};
				end
				for (int k = 0; k < bursts.size() && hit < 0; k++)    // vcount taken as sent
					if (hex_text({val[39:29], bursts[k][21:11], 7'd0, bursts[k][10:0]}) == text)
						hit = k;
				assert (hit >= 0) else report_mismatch($sformatf(
					"dump text %s matches no recent burst", text));
				for (int k = 0; k <= hit; k++)
					void'(bursts.pop_front());
				if (hit >= 0)
					dump_checks++;
			end
			rx_line.delete();
		end
	endtask

	initial begin : uart_decoder
		dump_byte_t b;
		@(negedge RSTBTN);
		forever begin
			@(negedge pclk);
			if (uart_tx == 1'b0) begin
				repeat (UDIV / 2) @(negedge pclk);    // Middle of the start bit
				for (int i = 0; i < 8; i++) begin
					repeat (UDIV) @(negedge pclk);
					b[i] = uart_tx;
				end
				repeat (UDIV) @(negedge pclk);
				assert (uart_tx == 1'b1) else report_problem("UART stop bit was missing");
				take_byte(b);
			end
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Stimulus
	//////////////////////////////////////////////////////////////////////
	initial begin : stimulus
		int goal;
		RSTBTN = 1'b1;
		sw = `SW_VGA;
		aux_wr = 1'b0;
		aux_in = '0;
		check_en = 1'b0;
		cyc = 0;
		ade_rise = -1;
		cur_target = -1;
		last_head_start = 0;
		{hs_prev, vs_prev, vde_prev, ade_prev} = '0;
		clear_trackers();
		for (int i = 0; i < 4; i++)
			fifo.push_back(new_word());
		aux_head = fifo[0];
		exp_t = ref_limits(`SW_VGA);
		exp_pol = ref_polarity(`SW_VGA);
		repeat (4) @(negedge pclk);
		RSTBTN = 1'b0;
		@(negedge pclk);
		aux_in = new_word();                // First write sets the burst position
		aux_wr = 1'b1;
		cur_target = int'(aux_in[`AUX_START_LSB +: `COORD_W]);
		@(negedge pclk);
		aux_wr = 1'b0;
		repeat (frame_len(exp_t)) @(negedge pclk);    // Settling frame
		clear_trackers();
		check_en = 1'b1;
		goal = vs_checks + 1;
		while (vs_checks < goal)
			@(negedge pclk);
		check_en = 1'b0;
		sw = `SW_SVGA;
		exp_t = ref_limits(`SW_SVGA);
		exp_pol = ref_polarity(`SW_SVGA);
		repeat (8) @(negedge pclk);         // Counters keep running through the switch
		clear_trackers();
		check_en = 1'b1;
		goal = vs_checks + 1;
		while (vs_checks < goal)
			@(negedge pclk);
		check_en = 1'b0;
		repeat (1500) @(negedge pclk);      // Let the last dump line drain
		if (hs_checks == 0 || vde_checks == 0 || burst_checks == 0 || dump_checks == 0)
			report_problem("some behaviour was never observed during the run");
		$display("Checks: hsync %0d, vde %0d, vsync %0d, bursts %0d, dump lines %0d, errors %0d",
			hs_checks, vde_checks, vs_checks, burst_checks, dump_checks, errors);
		if (errors == 0)
			$display("RESULT: PASS");
		else
			$display("RESULT: FAIL");
		$finish;
	end

	initial begin : watchdog
		int limit;
		limit = 3 * frame_len(ref_limits(`SW_VGA)) + 2 * frame_len(ref_limits(`SW_SVGA)) + MARGIN;
		repeat (limit) @(posedge pclk);
		$display("Timeout: the tests did not finish within %0d clock cycles", limit);
		$display("RESULT: FAIL");
		$finish;
	end

endmodule

/* sim.f */
+incdir+hdl
hdl/video_pkg.sv
hdl/aux_pkg.sv
hdl/mode_table.sv
hdl/video_timing.sv
hdl/aux_scheduler.sv
hdl/aux_dump.sv
hdl/uart_tx.sv
hdl/video_aux_top.sv
sim/tb_clk.sv
sim/tb_video_aux.sv

/* run.sh */
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module tb_video_aux -f sim.f -o vsim \
	&& ./obj_dir/vsim | tee /dev/stderr | grep -q "RESULT: PASS" \
	&& echo "Simulation passed" \
	|| { echo "Simulation failed"; exit 1; }
